// File: hazard_ctrl_asserts.sv
`timescale 1ns/100ps
`default_nettype none

`include "hazard_macros.svh"

module hazard_ctrl_asserts
    import hazard_pkg::*;
(
    input wire             clk,
    input wire             rst_n,
    input ctrl_state_e     state,           // controller fsm state
    input wire             hazard,          // branch or load-use conflict
    input wire             pc_overflow,
    input stage_ctrl_vec_t hazard_control,
    input stage_entry_t    ex_entry,        // id/ex register as seen by the unit
    input stage_entry_t    mem_entry        // ex/mem register
);

    int assert_fails = 0;                   // failed assertion count

    function automatic logic all_flush(input stage_ctrl_vec_t codes);
        all_flush = 1'b1;
        for (int i = 0; i < `STAGE_CNT; i++) begin
            if (codes[i] != CTRL_FLUSH) all_flush = 1'b0;
        end
    endfunction

    // interrupt keeps every stage empty
    interrupt_flush: assert property (@(posedge clk) disable iff (!rst_n)
        state == ST_INTERRUPT |-> all_flush(hazard_control)
            ##1 (ex_entry == '0 && mem_entry == '0))
        else begin
            $error("interrupt state with a stage that is not flushed");
            assert_fails++;
        end

    // older work always drains
    late_stages_move: assert property (@(posedge clk) disable iff (!rst_n)
        hazard_control[`STAGE_MEM] != CTRL_STALL && hazard_control[`STAGE_WB] != CTRL_STALL)
        else begin
            $error("mem or wb stage stalled");
            assert_fails++;
        end

    // the bubble must actually land in ex at the next edge
    hazard_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        state == ST_RUN && hazard && !pc_overflow
            |-> hazard_control[`STAGE_EX] == CTRL_BUBBLE ##1 ex_entry == '0)
        else begin
            $error("hazard without a bubble into ex");
            assert_fails++;
        end

endmodule

bind hazard_unit hazard_ctrl_asserts u_asserts (
    .clk            (clk),
    .rst_n          (rst_n),
    .state          (state),
    .hazard         (hazard),
    .pc_overflow    (pc_overflow),
    .hazard_control (hazard_control),
    .ex_entry       (ex_entry),
    .mem_entry      (mem_entry)
);

`default_nettype wire

// File: hazard_ctrl_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "hazard_macros.svh"

module hazard_ctrl_tb
    import hazard_pkg::*;
();

    typedef enum logic [2:0] {K_ADD, K_ADD_ZERO, K_LW, K_SW, K_BEQ, K_J} kind_e;

    typedef struct packed {
        kind_e      producer;
        logic [1:0] gap;                    // nops between producer and consumer
        kind_e      consumer;
        logic [1:0] hazard_cycles;          // expected cpu_hazard cycles
        issue_e     issue;                  // expected cause while they last
    } test_entry_t;

    localparam int        num_tests       = 14;
    localparam int        drain_nops      = 5;
    localparam int        watchdog_cycles = num_tests * 12 + 40;
    localparam isa_word_t nop             = '0;

    logic            clk;
    logic            rst_n;
    logic            uart_complete;
    isa_word_t       instr;
    isa_word_t       pc;
    stage_ctrl_vec_t hazard_control;
    cpu_state_e      cpu_state;
    issue_e          issue_type;
    test_entry_t     tests [num_tests];
    int              error_count = 0;
    int              test_count  = 0;
    int              test_fails  = 0;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    hazard_ctrl_top uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .uart_complete  (uart_complete),
        .instr          (instr),
        .pc             (pc),
        .hazard_control (hazard_control),
        .cpu_state      (cpu_state),
        .issue_type     (issue_type)
    );

    function automatic test_entry_t table_row(kind_e p, int gap, kind_e c, int cycles, issue_e is);
        table_row = '{p, gap[1:0], c, cycles[1:0], is};
    endfunction

    // dst is written, src is read, other fills the remaining register field
    function automatic isa_word_t encode(kind_e k, reg_idx_t dst, reg_idx_t src, reg_idx_t other);
        case (k)
            K_ADD:      encode = {`OP_RTYPE, src, other, dst, 5'd0, 6'h20};
            K_ADD_ZERO: encode = {`OP_RTYPE, src, other, 5'd0, 5'd0, 6'h20};  // add $0
            K_LW:       encode = {`OP_LW, other, dst, 16'h0010};
            K_SW:       encode = {`OP_SW, other, src, 16'h0008};  // stored value in rt
            K_BEQ:      encode = {`OP_BEQ, src, other, 16'h0004};
            default:    encode = {`OP_J, src, 21'h000040};        // target bits overlap rs
        endcase
    endfunction

    function automatic string kind_text(kind_e k);
        case (k)
            K_ADD:      kind_text = "add";
            K_ADD_ZERO: kind_text = "add $0";
            K_LW:       kind_text = "lw";
            K_SW:       kind_text = "sw";
            K_BEQ:      kind_text = "beq";
            default:    kind_text = "j";
        endcase
    endfunction

    function automatic isa_word_t random_pc();
        int unsigned word_addr;
        word_addr = $urandom_range(`PC_MAX_VALUE / 4 - 32, 0);  // leaves room for one entry
        random_pc = word_addr << 2;
    endfunction

    function automatic logic codes_all(input stage_ctrl_e code);
        codes_all = 1'b1;
        for (int i = 0; i < `STAGE_CNT; i++) begin
            if (hazard_control[i] != code) codes_all = 1'b0;
        end
    endfunction

    task automatic expect_true(input logic ok, input string what);
        assert (ok) else begin
            $display("Error at %0d ns: %s", $time, what);
            error_count++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            test_fails++;
            $display("test %0d %s: %0d errors", test_count, name, error_count - errors_before);
        end
    endtask

    task automatic check_reset_release();
        int errors_before;
        errors_before = error_count;
        wait (rst_n === 1'b1);
        @(negedge clk);                     // outputs settled mid-cycle
        expect_true(cpu_state == CPU_IDLE && codes_all(CTRL_FLUSH), "no idle flush after reset");
        @(negedge clk);
        expect_true(cpu_state == CPU_RUN && codes_all(CTRL_RUN), "no run state after idle");
        @(posedge clk);
        finish_test("reset release", errors_before);
    endtask

    // starts and ends right after a rising edge
    task automatic run_entry(input int n);
        test_entry_t t;
        isa_word_t   prog [$];
        reg_idx_t    dst;
        reg_idx_t    other;
        isa_word_t   cur_pc;
        int          idx;
        int          hz_cycles;
        int          errors_before;
        logic        take;
        t             = tests[n];
        errors_before = error_count;
        dst           = (t.producer == K_ADD_ZERO) ? 5'd0 : reg_idx_t'($urandom_range(31, 1));
        other         = reg_idx_t'($urandom_range(31, 1));
        cur_pc        = random_pc();
        prog.push_back(encode(t.producer, dst, other, other));
        repeat (t.gap) prog.push_back(nop);
        prog.push_back(encode(t.consumer, other, dst, other));  // reads the producer result
        repeat (drain_nops) prog.push_back(nop);
        idx       = 0;
        hz_cycles = 0;
        instr <= prog[0];
        pc    <= cur_pc;
        while (idx < prog.size()) begin
            @(negedge clk);
            if (cpu_state == CPU_HAZARD) begin
                hz_cycles++;
                expect_true(issue_type == t.issue, "wrong issue type during hazard");
                expect_true(hazard_control[`STAGE_IF] == CTRL_STALL
                            && hazard_control[`STAGE_ID] == CTRL_STALL
                            && hazard_control[`STAGE_EX] == CTRL_BUBBLE
                            && hazard_control[`STAGE_MEM] == CTRL_RUN
                            && hazard_control[`STAGE_WB] == CTRL_RUN, "wrong codes during hazard");
            end else begin
                expect_true(cpu_state == CPU_RUN && issue_type == ISSUE_NONE
                            && codes_all(CTRL_RUN), "not all stages running without hazard");
            end
            take = (hazard_control[`STAGE_IF] == CTRL_RUN);  // fetch honours the if code
            @(posedge clk);
            if (take) begin
                idx++;
                cur_pc = cur_pc + 4;
                if (idx < prog.size()) begin
                    instr <= prog[idx];
                    pc    <= cur_pc;
                end
            end
        end
        expect_true(hz_cycles == t.hazard_cycles, $sformatf("%0d hazard cycles, expected %0d",
                    hz_cycles, t.hazard_cycles));
        finish_test($sformatf("%s, gap %0d, %s", kind_text(t.producer), t.gap,
                    kind_text(t.consumer)), errors_before);
    endtask

    task automatic check_interrupt();
        int errors_before;
        errors_before = error_count;
        instr <= nop;
        pc    <= `PC_MAX_VALUE + 4;         // first word past the program
        @(negedge clk);
        expect_true(issue_type == ISSUE_PC_OVERFLOW && codes_all(CTRL_FLUSH), "overflow not seen");
        @(posedge clk);
        pc <= random_pc();                  // legal again before the restart
        repeat (4) begin
            @(negedge clk);
            expect_true(cpu_state == CPU_INTERRUPT && issue_type == ISSUE_PC_OVERFLOW
                        && codes_all(CTRL_FLUSH), "interrupt not held until upload");
            @(posedge clk);
        end
        uart_complete <= 1'b1;              // one-cycle upload done pulse
        @(posedge clk);
        uart_complete <= 1'b0;
        @(negedge clk);
        expect_true(cpu_state == CPU_IDLE && codes_all(CTRL_FLUSH), "no idle cycle after upload");
        @(negedge clk);
        expect_true(cpu_state == CPU_RUN && codes_all(CTRL_RUN), "no restart after upload");
        @(posedge clk);
        finish_test("pc overflow interrupt", errors_before);
    endtask

    task automatic load_table();
        tests[0]  = table_row(K_LW, 0, K_ADD, 1, ISSUE_LOAD_USE);
        tests[1]  = table_row(K_LW, 1, K_ADD, 0, ISSUE_NONE);
        tests[2]  = table_row(K_LW, 3, K_ADD, 0, ISSUE_NONE);
        tests[3]  = table_row(K_ADD, 0, K_BEQ, 2, ISSUE_BRANCH_DEP);
        tests[4]  = table_row(K_ADD, 1, K_BEQ, 1, ISSUE_BRANCH_DEP);
        tests[5]  = table_row(K_ADD, 2, K_BEQ, 0, ISSUE_NONE);
        tests[6]  = table_row(K_ADD, 3, K_BEQ, 0, ISSUE_NONE);
        tests[7]  = table_row(K_LW, 0, K_BEQ, 2, ISSUE_BRANCH_DEP);  // branch beats load-use
        tests[8]  = table_row(K_ADD, 0, K_J, 0, ISSUE_NONE);
        tests[9]  = table_row(K_LW, 0, K_J, 0, ISSUE_NONE);
        tests[10] = table_row(K_ADD_ZERO, 0, K_BEQ, 0, ISSUE_NONE);
        tests[11] = table_row(K_ADD, 0, K_ADD, 0, ISSUE_NONE);
        tests[12] = table_row(K_LW, 1, K_SW, 0, ISSUE_NONE);
        tests[13] = table_row(K_LW, 0, K_SW, 1, ISSUE_LOAD_USE);     // rt of a store is read
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("sim failed");
        $finish;
    end

    initial begin
        void'($urandom(79));
        uart_complete = 1'b0;
        instr         = nop;
        pc            = '0;
        load_table();
        check_reset_release();
        for (int n = 0; n < num_tests; n++) begin
            run_entry(n);
        end
        check_interrupt();
        error_count += uut.u_hazard_unit.u_asserts.assert_fails;  // bound assertion failures
        $display("tests %0d, failed %0d, errors %0d", test_count, test_fails, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hazard_ctrl_top.f
+incdir+.
hazard_pkg.sv
instr_classifier.sv
stage_tracker.sv
hazard_unit.sv
hazard_ctrl_top.sv
tb_clock_gen.sv
hazard_ctrl_asserts.sv
hazard_ctrl_tb.sv

// File: hazard_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_ctrl_top
    import hazard_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,          // synchronous, active low
    input  wire             uart_complete,  // upload done pulse
    input  isa_word_t       instr,          // fetched instruction
    input  isa_word_t       pc,             // its address
    output stage_ctrl_vec_t hazard_control, // per-stage codes, fetch obeys if
    output cpu_state_e      cpu_state,
    output issue_e          issue_type
);

    isa_word_t    id_instr;                 // if/id contents
    instr_class_t id_class;                 // decode of id_instr
    stage_entry_t ex_entry;
    stage_entry_t mem_entry;

    // decode of the instruction in id
    instr_classifier u_instr_classifier (
        .id_instr (id_instr),
        .id_class (id_class)
    );

    // pipeline registers carrying tracked fields forward
    stage_tracker u_stage_tracker (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr          (instr),
        .id_class       (id_class),
        .hazard_control (hazard_control),   // fed back from the hazard unit
        .id_instr       (id_instr),
        .ex_entry       (ex_entry),
        .mem_entry      (mem_entry)
    );

    // hazard detection, interrupt fsm and status
    hazard_unit u_hazard_unit (
        .clk            (clk),
        .rst_n          (rst_n),
        .uart_complete  (uart_complete),
        .pc             (pc),
        .id_class       (id_class),
        .ex_entry       (ex_entry),
        .mem_entry      (mem_entry),
        .hazard_control (hazard_control),
        .cpu_state      (cpu_state),
        .issue_type     (issue_type)
    );

endmodule

`default_nettype wire

// File: hazard_macros.svh
`ifndef HAZARD_MACROS_SVH
`define HAZARD_MACROS_SVH

// datapath widths
`define ISA_WIDTH            32             // instruction and pc width
`define REG_FILE_ADDR_WIDTH  5              // 32 architectural registers

// pipeline stage registers, index into the control vector
`define STAGE_CNT            5              // if, id, ex, mem, wb
`define STAGE_IF             0              // fetch
`define STAGE_ID             1              // decode
`define STAGE_EX             2              // execute
`define STAGE_MEM            3              // data memory access
`define STAGE_WB             4              // write back

// last legal instruction address, byte addressed
`define PC_MAX_VALUE         32'h0000_3ffc  // top of the 16 KiB program space

// MIPS primary opcodes
`define OP_RTYPE             6'h00          // funct field selects the operation
`define OP_J                 6'h02          // jump
`define OP_JAL               6'h03          // jump and link
`define OP_BEQ               6'h04          // branch if equal
`define OP_BNE               6'h05          // branch if not equal
`define OP_ADDI              6'h08          // add immediate
`define OP_LW                6'h23          // load word
`define OP_SW                6'h2b          // store word

// MIPS funct codes
`define FUNCT_JR             6'h08          // jump register

`endif

// File: hazard_pkg.sv
`default_nettype none

`include "hazard_macros.svh"

package hazard_pkg;

    typedef logic [`ISA_WIDTH-1:0]           isa_word_t;  // instruction word or pc
    typedef logic [`REG_FILE_ADDR_WIDTH-1:0] reg_idx_t;   // register file index

    // what a stage register does at the next rising edge
    typedef enum logic [1:0] {
        CTRL_RUN    = 2'd0,                 // load from the previous stage
        CTRL_STALL  = 2'd1,                 // hold current contents
        CTRL_BUBBLE = 2'd2,                 // load an empty entry
        CTRL_FLUSH  = 2'd3                  // clear
    } stage_ctrl_e;

    typedef stage_ctrl_e [`STAGE_CNT-1:0] stage_ctrl_vec_t;  // index 0 is if, 4 is wb

    typedef enum logic [1:0] {
        ST_IDLE      = 2'd0,                // one cycle after reset or upload
        ST_RUN       = 2'd1,                // normal issue, hazards handled here
        ST_INTERRUPT = 2'd2                 // pc overflow, waiting for upload
    } ctrl_state_e;

    typedef enum logic [1:0] {
        CPU_IDLE      = 2'd0,
        CPU_RUN       = 2'd1,
        CPU_HAZARD    = 2'd2,
        CPU_INTERRUPT = 2'd3
    } cpu_state_e;                          // shown by the display unit

    typedef enum logic [2:0] {
        ISSUE_NONE        = 3'd0,
        ISSUE_LOAD_USE    = 3'd1,           // id needs a load still in ex
        ISSUE_BRANCH_DEP  = 3'd2,           // branch needs a result in ex or mem
        ISSUE_PC_OVERFLOW = 3'd3            // fetch ran past the program
    } issue_e;

    typedef struct packed {
        logic     i_type;                   // addi, lw, sw, beq, bne
        logic     r_type;                   // opcode 0, nop excluded
        logic     j;
        logic     jr;
        logic     jal;
        logic     branch;                   // beq or bne
        logic     store;
        logic     mem_read;                 // load
        logic     reg_write;                // writes reg_dest_idx
        reg_idx_t reg_1_idx;                // rs
        reg_idx_t reg_2_idx;                // rt
        reg_idx_t reg_dest_idx;
    } instr_class_t;                        // 24 bits

    typedef struct packed {
        reg_idx_t reg_dest_idx;
        logic     reg_write;
        logic     mem_read;
    } stage_entry_t;                        // 7 bits, what hazard check needs

endpackage

`default_nettype wire

// File: hazard_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "hazard_macros.svh"

module hazard_unit
    import hazard_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,
    input  wire             uart_complete,  // one-cycle pulse, program upload done
    input  isa_word_t       pc,             // address of the fetched word
    input  instr_class_t    id_class,       // instruction now in id
    input  stage_entry_t    ex_entry,       // instruction now in ex
    input  stage_entry_t    mem_entry,      // instruction now in mem
    output stage_ctrl_vec_t hazard_control, // one code per stage register
    output cpu_state_e      cpu_state,      // for the display unit
    output issue_e          issue_type      // hazard or interrupt cause
);

    ctrl_state_e state;
    ctrl_state_e state_nxt;
    logic        reg_1_valid;               // rs is really read
    logic        reg_2_valid;               // rt is really read
    logic        ex_conflict;
    logic        mem_conflict;
    logic        branch_dep;
    logic        load_use;
    logic        hazard;
    logic        pc_overflow;

    // source register matches a stage that will write it
    function automatic logic src_hit(
        input reg_idx_t     src,
        input logic         valid,
        input stage_entry_t entry
    );
        src_hit = valid && (src != '0) && entry.reg_write && (src == entry.reg_dest_idx);
    endfunction

    // same code on every stage
    function automatic stage_ctrl_vec_t all_codes(input stage_ctrl_e code);
        for (int i = 0; i < `STAGE_CNT; i++) begin
            all_codes[i] = code;
        end
    endfunction

    assign reg_1_valid = !(id_class.j || id_class.jal);  // jumps carry no rs
    assign reg_2_valid = id_class.r_type | id_class.store | id_class.branch;

    assign ex_conflict  = src_hit(id_class.reg_1_idx, reg_1_valid, ex_entry)
                        | src_hit(id_class.reg_2_idx, reg_2_valid, ex_entry);
    assign mem_conflict = src_hit(id_class.reg_1_idx, reg_1_valid, mem_entry)
                        | src_hit(id_class.reg_2_idx, reg_2_valid, mem_entry);

    // branch compares in id, so it waits for ex and mem results
    assign branch_dep  = id_class.branch & (ex_conflict | mem_conflict);
    assign load_use    = ex_entry.mem_read & ex_conflict;  // load data not ready yet
    assign hazard      = branch_dep | load_use;
    assign pc_overflow = (pc > `PC_MAX_VALUE);

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:      state_nxt = ST_RUN;
            ST_RUN:       if (pc_overflow) state_nxt = ST_INTERRUPT;
            ST_INTERRUPT: if (uart_complete) state_nxt = ST_IDLE;  // restart after upload
            default:      state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // codes and status, valid in the same cycle
    always_comb begin
        hazard_control = all_codes(CTRL_FLUSH);
        cpu_state      = CPU_IDLE;
        issue_type     = ISSUE_NONE;
        case (state)
            ST_RUN: begin
                cpu_state = CPU_RUN;
                if (pc_overflow) begin
                    issue_type = ISSUE_PC_OVERFLOW;  // flush now, interrupt next edge
                end else if (hazard) begin
                    hazard_control                 = all_codes(CTRL_RUN);
                    hazard_control[`STAGE_IF]  = CTRL_STALL;   // refetch same word
                    hazard_control[`STAGE_ID]  = CTRL_STALL;   // keep dependent instruction
                    hazard_control[`STAGE_EX]  = CTRL_BUBBLE;  // insert a nop
                    hazard_control[`STAGE_MEM] = CTRL_RUN;     // older work drains
                    hazard_control[`STAGE_WB]  = CTRL_RUN;
                    cpu_state                      = CPU_HAZARD;
                    // branch wins when both apply
                    issue_type = branch_dep ? ISSUE_BRANCH_DEP : ISSUE_LOAD_USE;
                end else begin
                    hazard_control = all_codes(CTRL_RUN);
                end
            end
            ST_INTERRUPT: begin
                cpu_state  = CPU_INTERRUPT;     // all stages held empty
                issue_type = ISSUE_PC_OVERFLOW;
            end
            default: begin
                cpu_state  = CPU_IDLE;          // flush after reset or upload
                issue_type = ISSUE_NONE;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: instr_classifier.sv
`timescale 1ns/100ps
`default_nettype none

`include "hazard_macros.svh"

module instr_classifier
    import hazard_pkg::*;
(
    input  isa_word_t    id_instr,          // instruction held in if/id
    output instr_class_t id_class           // flags and register indices
);

    logic [5:0] opcode;                     // bits 31:26
    logic [5:0] funct;                      // bits 5:0, r-type only
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   rd;
    logic       is_nop;                     // all-zero word
    logic       op_rtype;
    logic       op_jr;
    logic       op_addi;
    logic       op_lw;
    logic       op_sw;
    logic       op_beq;
    logic       op_bne;

    assign opcode = id_instr[31:26];
    assign rs     = id_instr[25:21];
    assign rt     = id_instr[20:16];
    assign rd     = id_instr[15:11];
    assign funct  = id_instr[5:0];
    assign is_nop = (id_instr == '0);       // sll $0,$0,0 treated as no-op

    assign op_rtype = (opcode == `OP_RTYPE) && !is_nop;
    assign op_jr    = op_rtype && (funct == `FUNCT_JR);
    assign op_addi  = (opcode == `OP_ADDI);
    assign op_lw    = (opcode == `OP_LW);
    assign op_sw    = (opcode == `OP_SW);
    assign op_beq   = (opcode == `OP_BEQ);
    assign op_bne   = (opcode == `OP_BNE);

    always_comb begin
        id_class           = '0;
        id_class.r_type    = op_rtype;
        id_class.jr        = op_jr;
        id_class.j         = (opcode == `OP_J);
        id_class.jal       = (opcode == `OP_JAL);
        id_class.branch    = op_beq | op_bne;
        id_class.store     = op_sw;
        id_class.mem_read  = op_lw;
        id_class.i_type    = op_addi | op_lw | op_sw | op_beq | op_bne;
        id_class.reg_1_idx = rs;            // validity is judged by hazard_unit
        id_class.reg_2_idx = rt;

        // destination and write enable per class
        if (op_rtype && !op_jr) begin
            id_class.reg_dest_idx = rd;
            id_class.reg_write    = 1'b1;
        end else if (op_addi || op_lw) begin
            id_class.reg_dest_idx = rt;     // i-type result goes to rt
            id_class.reg_write    = 1'b1;
        end else if (opcode == `OP_JAL) begin
            id_class.reg_dest_idx = 5'd31;  // link register ra
            id_class.reg_write    = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: stage_tracker.sv
`timescale 1ns/100ps
`default_nettype none

`include "hazard_macros.svh"

module stage_tracker
    import hazard_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,
    input  isa_word_t       instr,          // fetched word from if
    input  instr_class_t    id_class,       // decode of id_instr
    input  stage_ctrl_vec_t hazard_control, // per-stage codes from hazard_unit
    output isa_word_t       id_instr,       // if/id register
    output stage_entry_t    ex_entry,       // id/ex register
    output stage_entry_t    mem_entry       // ex/mem register
);

    stage_entry_t id_entry;                 // id instruction reduced to tracked fields
    stage_ctrl_e  id_code;
    stage_ctrl_e  ex_code;
    stage_ctrl_e  mem_code;

    // next value of a tracked entry under its stage code
    function automatic stage_entry_t step_entry(
        input stage_ctrl_e  code,
        input stage_entry_t held,
        input stage_entry_t incoming
    );
        case (code)
            CTRL_RUN:   step_entry = incoming;
            CTRL_STALL: step_entry = held;
            default:    step_entry = '0;    // bubble or flush, no write, no read
        endcase
    endfunction

    assign id_code  = hazard_control[`STAGE_ID];
    assign ex_code  = hazard_control[`STAGE_EX];
    assign mem_code = hazard_control[`STAGE_MEM];

    always_comb begin
        id_entry              = '0;
        id_entry.reg_dest_idx = id_class.reg_dest_idx;
        id_entry.reg_write    = id_class.reg_write;
        id_entry.mem_read     = id_class.mem_read;
    end

    // if/id follows the id code
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_instr <= '0;                 // empty slot decodes as nop
        end else begin
            case (id_code)
                CTRL_RUN:   id_instr <= instr;
                CTRL_STALL: id_instr <= id_instr;  // hold the waiting instruction
                default:    id_instr <= '0;
            endcase
        end
    end

    // id/ex and ex/mem follow the ex and mem codes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_entry  <= '0;
            mem_entry <= '0;
        end else begin
            ex_entry  <= step_entry(ex_code, ex_entry, id_entry);
            mem_entry <= step_entry(mem_code, mem_entry, ex_entry);
        end
    end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int period_ns    = 10,        // 100 MHz
    parameter int reset_cycles = 10         // rst_n low for this many rising edges
) (
    output logic clk,
    output logic rst_n                      // synchronous, active low
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;                      // released on a rising edge
    end

endmodule

`default_nettype wire
